//--- logic/w5500_settings.svh
// W5500 widths, register map, init values and codes
// init values assume a fixed 192.168.1.x network; socket 0 only
`ifndef W5500_SETTINGS_SVH
`define W5500_SETTINGS_SVH

`define W5500_BYTE_W        8
`define W5500_LEN_W         16
`define W5500_INIT_REGS     9
`define W5500_MAX_PAYLOAD   6
`define W5500_HDR_BYTES     3

// common block registers
`define W5500_ADDR_MR       16'h0000
`define W5500_ADDR_IMR      16'h0016
`define W5500_ADDR_GAR      16'h0001
`define W5500_ADDR_SUBR     16'h0005
`define W5500_ADDR_SHAR     16'h0009
`define W5500_ADDR_SIPR     16'h000f
`define W5500_ADDR_SIMR     16'h0018

// socket block registers
`define W5500_ADDR_SN_MR    16'h0000
`define W5500_ADDR_SN_CR    16'h0001
`define W5500_ADDR_SN_SR    16'h0003
`define W5500_ADDR_SN_PORT  16'h0004

`define W5500_VAL_MR        8'h00
`define W5500_VAL_IMR       8'h00
`define W5500_VAL_GAR       32'hc0a80101
`define W5500_VAL_SUBR      32'hffffff00
`define W5500_VAL_SHAR      48'h05689c010503
`define W5500_VAL_SIPR      32'hc0a80102
`define W5500_VAL_SIMR      8'h01
`define W5500_VAL_SN_MR     8'h01
`define W5500_VAL_SN_PORT   16'h1388

`define W5500_BSB_COMMON    5'b00000
`define W5500_BSB_SOCK0     5'b00001

`define W5500_CMD_OPEN      8'h01
`define W5500_CMD_LISTEN    8'h02
`define W5500_CMD_DISCON    8'h08

`define W5500_SR_CLOSED      8'h00
`define W5500_SR_INIT        8'h13
`define W5500_SR_LISTEN      8'h14
`define W5500_SR_ESTABLISHED 8'h17
`define W5500_SR_CLOSE_WAIT  8'h1c

`endif

//--- logic/w5500_pkg.sv
// shared types for the W5500 command sequencer
// payload is right justified, sent most significant byte first
`default_nettype none

`include "w5500_settings.svh"

package w5500_pkg;

    typedef logic [`W5500_BYTE_W-1:0] spi_byte_t;
    typedef logic [15:0]              reg_addr_t;
    typedef logic [4:0]               bsb_t;
    typedef logic [`W5500_LEN_W-1:0]  xfer_len_t;
    typedef logic [2:0]               payload_cnt_t;
    typedef logic [`W5500_BYTE_W-1:0] sock_status_t;

    // one SPI frame as seen by the frame writer
    typedef struct packed {
        reg_addr_t    addr;
        bsb_t         bsb;
        logic         write;
        payload_cnt_t count;
        logic [`W5500_MAX_PAYLOAD*`W5500_BYTE_W-1:0] payload;
    } frame_req_t;

    // transfer request to the SPI byte engine
    typedef struct packed {
        logic      start;
        logic      write;
        xfer_len_t length;
    } xfer_cmd_t;

    typedef enum logic [2:0] {
        init,
        init_wait,
        poll,
        poll_wait,
        capture,
        command,
        command_wait,
        established
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/w5500_init_rom.sv
// init frames for the W5500, all writes
// steps above the table size return an empty frame
`default_nettype none

`include "w5500_settings.svh"

module w5500_init_rom (
    input  wire [3:0]              step,
    output w5500_pkg::frame_req_t  frame
);

    function automatic w5500_pkg::frame_req_t make_write(
        input w5500_pkg::reg_addr_t    addr,
        input w5500_pkg::bsb_t         bsb,
        input w5500_pkg::payload_cnt_t count,
        input logic [`W5500_MAX_PAYLOAD*`W5500_BYTE_W-1:0] value
    );
        w5500_pkg::frame_req_t f;
        f.addr    = addr;
        f.bsb     = bsb;
        f.write   = 1'b1;
        f.count   = count;
        f.payload = value;
        return f;
    endfunction

    always_comb begin
        case (step)
            4'd0: frame = make_write(`W5500_ADDR_MR, `W5500_BSB_COMMON, 3'd1, `W5500_VAL_MR);
            4'd1: frame = make_write(`W5500_ADDR_IMR, `W5500_BSB_COMMON, 3'd1, `W5500_VAL_IMR);
            4'd2: frame = make_write(`W5500_ADDR_GAR, `W5500_BSB_COMMON, 3'd4, `W5500_VAL_GAR);
            4'd3: frame = make_write(`W5500_ADDR_SUBR, `W5500_BSB_COMMON, 3'd4,
                                     `W5500_VAL_SUBR);
            4'd4: frame = make_write(`W5500_ADDR_SHAR, `W5500_BSB_COMMON, 3'd6,
                                     `W5500_VAL_SHAR);
            4'd5: frame = make_write(`W5500_ADDR_SIPR, `W5500_BSB_COMMON, 3'd4,
                                     `W5500_VAL_SIPR);
            4'd6: frame = make_write(`W5500_ADDR_SIMR, `W5500_BSB_COMMON, 3'd1,
                                     `W5500_VAL_SIMR);
            // socket 0 block from here
            4'd7: frame = make_write(`W5500_ADDR_SN_MR, `W5500_BSB_SOCK0, 3'd1,
                                     `W5500_VAL_SN_MR);
            4'd8: frame = make_write(`W5500_ADDR_SN_PORT, `W5500_BSB_SOCK0, 3'd2,
                                     `W5500_VAL_SN_PORT);
            default: frame = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/w5500_frame_writer.sv
// pushes header and payload of one frame into the tx FIFO, then starts it
// one frame at a time; req is latched on acceptance
`default_nettype none

module w5500_frame_writer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire w5500_pkg::frame_req_t req,
    input  wire                     req_valid,
    output logic                    req_ready,
    output w5500_pkg::spi_byte_t    tx_byte,
    output logic                    tx_push,
    input  wire                     tx_full,
    output w5500_pkg::xfer_cmd_t    xfer
);

    typedef enum logic [1:0] {
        fw_idle,
        fw_push,
        fw_start
    } fw_state_t;

    fw_state_t             state;
    w5500_pkg::frame_req_t req_q;
    logic [3:0]            idx;
    logic [3:0]            last_idx;
    logic [3:0]            pay_sel;
    logic [3:0]            frame_bytes;

    //////////////////////////////
    // byte selection
    //////////////////////////////

    always_comb begin
        // reads clock one dummy byte after the header
        last_idx    = req_q.write ? 4'(`W5500_HDR_BYTES) + 4'(req_q.count) - 4'd1
                                  : 4'(`W5500_HDR_BYTES);
        frame_bytes = last_idx + 4'd1;
        pay_sel     = 4'(req_q.count) + 4'(`W5500_HDR_BYTES) - 4'd1 - idx;
        case (idx)
            4'd0: tx_byte = req_q.addr[15:8];
            4'd1: tx_byte = req_q.addr[7:0];
            4'd2: tx_byte = {req_q.bsb, req_q.write, 2'b00};
            default: tx_byte = req_q.payload[pay_sel*`W5500_BYTE_W +: `W5500_BYTE_W];
        endcase
    end

    assign req_ready   = (state == fw_idle);
    assign tx_push     = (state == fw_push) && !tx_full;
    assign xfer.start  = (state == fw_start);
    assign xfer.write  = req_q.write;
    assign xfer.length = w5500_pkg::xfer_len_t'(frame_bytes) * `W5500_BYTE_W;

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fw_idle;
            idx   <= 4'd0;
        end else begin
            case (state)
                fw_idle: begin
                    if (req_valid) begin
                        idx   <= 4'd0;
                        state <= fw_push;
                    end
                end
                fw_push: begin
                    // stall on full, no byte lost
                    if (!tx_full) begin
                        idx <= idx + 4'd1;
                        if (idx == last_idx - 4'(!req_q.write)) begin
                            state <= fw_start;
                        end
                    end
                end
                default: state <= fw_idle;
            endcase
        end
    end

    // payload register, no reset
    always_ff @(posedge clk) begin
        if (state == fw_idle && req_valid) begin
            req_q <= req;
        end
    end

endmodule

`default_nettype wire

//--- logic/w5500_socket_sequencer.sv
// init table, then socket 0 status polling until ESTABLISHED
// waits for busy high then low after every request
`default_nettype none

`include "w5500_settings.svh"

module w5500_socket_sequencer (
    input  wire                    clk,
    input  wire                    rst,
    output w5500_pkg::frame_req_t  req,
    output logic                   req_valid,
    input  wire                    req_ready,
    input  wire                    busy,
    input  wire w5500_pkg::spi_byte_t rx_byte,
    output logic                   rx_pop,
    input  wire                    rx_empty,
    output logic                   sock_established
);

    w5500_pkg::seq_state_t  state;
    logic [3:0]             step;
    w5500_pkg::spi_byte_t   cmd_q;
    logic                   seen_busy;
    logic                   xfer_done;
    w5500_pkg::frame_req_t  rom_frame;
    w5500_pkg::frame_req_t  poll_frame;
    w5500_pkg::frame_req_t  cmd_frame;
    w5500_pkg::sock_status_t status;
    w5500_pkg::spi_byte_t   cmd_next;
    logic                   cmd_needed;

    w5500_init_rom i_init_rom (
        .step  (step),
        .frame (rom_frame)
    );

    //////////////////////////////
    // frames and status decode
    //////////////////////////////

    always_comb begin
        poll_frame       = '0;
        poll_frame.addr  = `W5500_ADDR_SN_SR;
        poll_frame.bsb   = `W5500_BSB_SOCK0;
        cmd_frame        = '0;
        cmd_frame.addr   = `W5500_ADDR_SN_CR;
        cmd_frame.bsb    = `W5500_BSB_SOCK0;
        cmd_frame.write  = 1'b1;
        cmd_frame.count  = 3'd1;
        cmd_frame.payload[`W5500_BYTE_W-1:0] = cmd_q;
        case (state)
            w5500_pkg::init, w5500_pkg::init_wait:       req = rom_frame;
            w5500_pkg::command, w5500_pkg::command_wait: req = cmd_frame;
            default:                                     req = poll_frame;
        endcase
    end

    always_comb begin
        status     = w5500_pkg::sock_status_t'(rx_byte);
        cmd_next   = '0;
        cmd_needed = 1'b0;
        case (status)
            `W5500_SR_CLOSED: begin
                cmd_next   = `W5500_CMD_OPEN;
                cmd_needed = 1'b1;
            end
            `W5500_SR_INIT: begin
                cmd_next   = `W5500_CMD_LISTEN;
                cmd_needed = 1'b1;
            end
            `W5500_SR_CLOSE_WAIT: begin
                cmd_next   = `W5500_CMD_DISCON;
                cmd_needed = 1'b1;
            end
            default:          cmd_needed = 1'b0;
        endcase
    end

    assign req_valid = (state == w5500_pkg::init) || (state == w5500_pkg::poll)
                    || (state == w5500_pkg::command);
    assign rx_pop    = (state == w5500_pkg::capture) && !rx_empty;
    assign sock_established = (state == w5500_pkg::established);
    assign xfer_done = seen_busy && !busy;

    // end of transfer is busy seen high, then low
    always_ff @(posedge clk) begin
        if (rst || (req_valid && req_ready)) begin
            seen_busy <= 1'b0;
        end else if (busy) begin
            seen_busy <= 1'b1;
        end
    end

    //////////////////////////////
    // main FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= w5500_pkg::init;
            step  <= 4'd0;
        end else begin
            case (state)
                w5500_pkg::init:
                    if (req_ready) state <= w5500_pkg::init_wait;
                w5500_pkg::init_wait: begin
                    if (xfer_done) begin
                        if (step == 4'(`W5500_INIT_REGS - 1)) begin
                            state <= w5500_pkg::poll;
                        end else begin
                            step  <= step + 4'd1;
                            state <= w5500_pkg::init;
                        end
                    end
                end
                w5500_pkg::poll:
                    if (req_ready) state <= w5500_pkg::poll_wait;
                w5500_pkg::poll_wait:
                    if (xfer_done) state <= w5500_pkg::capture;
                w5500_pkg::capture: begin
                    if (!rx_empty) begin
                        if (status == `W5500_SR_ESTABLISHED) begin
                            state <= w5500_pkg::established;
                        end else if (cmd_needed) begin
                            state <= w5500_pkg::command;
                        end else begin
                            state <= w5500_pkg::poll;
                        end
                    end
                end
                w5500_pkg::command:
                    if (req_ready) state <= w5500_pkg::command_wait;
                w5500_pkg::command_wait:
                    if (xfer_done) state <= w5500_pkg::poll;
                default: state <= w5500_pkg::established;
            endcase
        end
    end

    // command byte, no reset
    always_ff @(posedge clk) begin
        if (rx_pop) begin
            cmd_q <= cmd_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/w5500_ctrl_top.sv
// W5500 controller top, sequencer in front of the frame writer
// SPI byte engine and both FIFOs are outside this block
`default_nettype none

module w5500_ctrl_top (
    input  wire                       clk,
    input  wire                       rst,
    output w5500_pkg::spi_byte_t      tx_byte,
    output logic                      tx_push,
    input  wire                       tx_full,
    output w5500_pkg::xfer_cmd_t      xfer,
    input  wire                       busy,
    input  wire w5500_pkg::spi_byte_t rx_byte,
    output logic                      rx_pop,
    input  wire                       rx_empty,
    output logic                      sock_established
);

    w5500_pkg::frame_req_t req;
    logic                  req_valid;
    logic                  req_ready;

    w5500_socket_sequencer i_sequencer (
        .clk              (clk),
        .rst              (rst),
        .req              (req),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .busy             (busy),
        .rx_byte          (rx_byte),
        .rx_pop           (rx_pop),
        .rx_empty         (rx_empty),
        .sock_established (sock_established)
    );

    w5500_frame_writer i_frame_writer (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .tx_byte   (tx_byte),
        .tx_push   (tx_push),
        .tx_full   (tx_full),
        .xfer      (xfer)
    );

endmodule

`default_nettype wire

//--- testbench/w5500_ctrl_asserts.sv
// protocol checks on the controller top, bound in below
// every failure raises $error and bumps fail_count for the testbench
`default_nettype none

module w5500_ctrl_asserts (
    input wire                       clk,
    input wire                       rst,
    input wire                       tx_push,
    input wire                       tx_full,
    input wire w5500_pkg::xfer_cmd_t xfer,
    input wire                       rx_pop,
    input wire                       rx_empty,
    input wire                       sock_established
);

    int unsigned fail_count = 0;

    push_not_full: assert property (@(posedge clk) disable iff (rst) tx_push |-> !tx_full)
    else begin
        fail_count++;
        $error("tx_push while tx_full is high");
    end

    start_one_cycle: assert property (@(posedge clk) disable iff (rst)
        xfer.start |=> !xfer.start)
    else begin
        fail_count++;
        $error("xfer.start held longer than one cycle");
    end

    pop_not_empty: assert property (@(posedge clk) disable iff (rst) rx_pop |-> !rx_empty)
    else begin
        fail_count++;
        $error("rx_pop while rx_empty is high");
    end

    // only reset may clear the connected flag
    established_sticky: assert property (@(posedge clk) disable iff (rst)
        sock_established |=> sock_established)
    else begin
        fail_count++;
        $error("sock_established fell without reset");
    end

endmodule

bind w5500_ctrl_top w5500_ctrl_asserts i_asserts (
    .clk              (clk),
    .rst              (rst),
    .tx_push          (tx_push),
    .tx_full          (tx_full),
    .xfer             (xfer),
    .rx_pop           (rx_pop),
    .rx_empty         (rx_empty),
    .sock_established (sock_established)
);

`default_nettype wire

//--- testbench/w5500_ctrl_tb.sv
// directed testbench for the W5500 controller top
// SPI engine and both FIFOs are behavioural models, one frame in flight
`default_nettype none

`include "w5500_settings.svh"

module w5500_ctrl_tb;

    localparam int max_frames       = 20;
    localparam int cycles_per_frame = 40;
    localparam int hold_cycles      = 100;

    logic                    clk;
    logic                    rst;
    logic                    tx_full;
    logic                    busy;
    w5500_pkg::spi_byte_t    rx_byte;
    logic                    rx_empty;
    w5500_pkg::spi_byte_t    tx_byte;
    logic                    tx_push;
    w5500_pkg::xfer_cmd_t    xfer;
    logic                    rx_pop;
    logic                    sock_established;

    // model state
    logic                    stall_en;
    logic                    read_xfer;
    int                      busy_left;
    int                      cycle;
    int                      last_push_cycle;
    w5500_pkg::spi_byte_t    tx_q[$];
    w5500_pkg::xfer_cmd_t    xfer_q[$];
    int                      gap_q[$];
    w5500_pkg::sock_status_t status_q[$];

    w5500_ctrl_top i_dut (
        .clk              (clk),
        .rst              (rst),
        .tx_byte          (tx_byte),
        .tx_push          (tx_push),
        .tx_full          (tx_full),
        .xfer             (xfer),
        .busy             (busy),
        .rx_byte          (rx_byte),
        .rx_pop           (rx_pop),
        .rx_empty         (rx_empty),
        .sock_established (sock_established)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // reporting and compares
    //////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_byte(
        input w5500_pkg::spi_byte_t got,
        input w5500_pkg::spi_byte_t exp,
        input string                what
    );
        if (got !== exp) begin
            fail_run($sformatf("Error at time %0t: %s got %02h expected %02h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_xfer(
        input w5500_pkg::xfer_cmd_t got,
        input w5500_pkg::xfer_cmd_t exp,
        input string                what
    );
        if (got !== exp) begin
            fail_run($sformatf("Error at time %0t: %s got start %b write %b length %0d, %s",
                               $time, what, got.start, got.write, got.length,
                               $sformatf("expected write %b length %0d", exp.write, exp.length)));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at time %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    //////////////////////////////
    // SPI engine, rx FIFO, tx monitor
    //////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            tx_full    <= 1'b0;
            busy       <= 1'b0;
            rx_empty   <= 1'b1;
        end else begin
            tx_full <= stall_en && ($urandom % 3 != 0);
            if (xfer.start) begin
                busy       <= 1'b1;
                busy_left  <= 2 + ($urandom % 8);
                read_xfer  <= !xfer.write;
            end else if (busy) begin
                if (busy_left == 1) begin
                    busy <= 1'b0;
                    // a read answers with the next scripted status
                    if (read_xfer && status_q.size() == 0) begin
                        fail_run("read transfer ended with no scripted status left");
                    end else if (read_xfer) begin
                        rx_byte  <= status_q.pop_front();
                        rx_empty <= 1'b0;
                    end
                end else begin
                    busy_left <= busy_left - 1;
                end
            end
            if (rx_pop) begin
                rx_empty <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst && tx_push) begin
            tx_q.push_back(tx_byte);
            last_push_cycle <= cycle;
        end
        if (!rst && xfer.start) begin
            xfer_q.push_back(xfer);
            gap_q.push_back(cycle - last_push_cycle);
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_asserts.fail_count != 0) begin
            fail_run("a protocol assertion on the DUT failed");
        end
    end

    initial begin
        repeat (max_frames * cycles_per_frame + hold_cycles) @(posedge clk);
        fail_run("timeout, the tests did not finish in the expected number of cycles");
    end

    //////////////////////////////
    // frame checks and tests
    //////////////////////////////

    task automatic expect_frame(
        input w5500_pkg::reg_addr_t    addr,
        input w5500_pkg::bsb_t         bsb,
        input logic                    wr,
        input w5500_pkg::payload_cnt_t cnt,
        input logic [47:0]             value,
        input string                   name
    );
        w5500_pkg::xfer_cmd_t exp_xfer;
        int                   nbytes;
        nbytes = `W5500_HDR_BYTES + (wr ? int'(cnt) : 0);
        while (xfer_q.size() == 0) begin
            @(negedge clk);
        end
        // reads clock one extra byte for the data
        exp_xfer.start  = 1'b1;
        exp_xfer.write  = wr;
        exp_xfer.length = w5500_pkg::xfer_len_t'(8 * (`W5500_HDR_BYTES + (wr ? int'(cnt) : 1)));
        check_xfer(xfer_q.pop_front(), exp_xfer, name);
        check_flag(gap_q.pop_front() == 1, 1'b1, {name, " start right after last byte"});
        check_flag(tx_q.size() == nbytes, 1'b1, {name, " byte count"});
        check_byte(tx_q.pop_front(), addr[15:8], {name, " address high"});
        check_byte(tx_q.pop_front(), addr[7:0], {name, " address low"});
        check_byte(tx_q.pop_front(), {bsb, wr, 2'b00}, {name, " control byte"});
        for (int i = 0; wr && i < int'(cnt); i++) begin
            check_byte(tx_q.pop_front(), value[(int'(cnt) - 1 - i) * 8 +: 8],
                       $sformatf("%s payload byte %0d", name, i));
        end
    endtask

    task automatic check_init_frame(input int step);
        case (step)
            0: expect_frame(`W5500_ADDR_MR, `W5500_BSB_COMMON, 1'b1, 3'd1, `W5500_VAL_MR, "MR");
            1: expect_frame(`W5500_ADDR_IMR, `W5500_BSB_COMMON, 1'b1, 3'd1, `W5500_VAL_IMR, "IMR");
            2: expect_frame(`W5500_ADDR_GAR, `W5500_BSB_COMMON, 1'b1, 3'd4, `W5500_VAL_GAR, "GAR");
            3: expect_frame(`W5500_ADDR_SUBR, `W5500_BSB_COMMON, 1'b1, 3'd4, `W5500_VAL_SUBR,
                            "SUBR");
            4: expect_frame(`W5500_ADDR_SHAR, `W5500_BSB_COMMON, 1'b1, 3'd6, `W5500_VAL_SHAR,
                            "SHAR");
            5: expect_frame(`W5500_ADDR_SIPR, `W5500_BSB_COMMON, 1'b1, 3'd4, `W5500_VAL_SIPR,
                            "SIPR");
            6: expect_frame(`W5500_ADDR_SIMR, `W5500_BSB_COMMON, 1'b1, 3'd1, `W5500_VAL_SIMR,
                            "SIMR");
            7: expect_frame(`W5500_ADDR_SN_MR, `W5500_BSB_SOCK0, 1'b1, 3'd1, `W5500_VAL_SN_MR,
                            "SN_MR");
            default: expect_frame(`W5500_ADDR_SN_PORT, `W5500_BSB_SOCK0, 1'b1, 3'd2,
                                  `W5500_VAL_SN_PORT, "SN_PORT");
        endcase
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_flag(tx_push, 1'b0, "tx_push after reset");
        check_flag(rx_pop, 1'b0, "rx_pop after reset");
        check_flag(xfer.start, 1'b0, "xfer.start after reset");
        check_flag(sock_established, 1'b0, "sock_established after reset");
    endtask

    // random tx_full stretches across the MAC frame
    task automatic test_backpressure_mac();
        stall_en = 1'b1;
        check_init_frame(4);
        stall_en = 1'b0;
    endtask

    task automatic test_first_poll();
        expect_frame(`W5500_ADDR_SN_SR, `W5500_BSB_SOCK0, 1'b0, 3'd0, 48'h0, "first poll");
    endtask

    task automatic test_status_response(
        input w5500_pkg::sock_status_t status,
        input logic                    has_cmd,
        input w5500_pkg::spi_byte_t    cmd,
        input string                   name
    );
        status_q.push_back(status);
        if (has_cmd) begin
            expect_frame(`W5500_ADDR_SN_CR, `W5500_BSB_SOCK0, 1'b1, 3'd1, 48'(cmd),
                         {name, " command"});
        end
        expect_frame(`W5500_ADDR_SN_SR, `W5500_BSB_SOCK0, 1'b0, 3'd0, 48'h0, {name, " poll"});
        check_flag(rx_empty, 1'b1, {name, " status popped"});
    endtask

    task automatic test_established();
        int waited;
        waited = 0;
        status_q.push_back(`W5500_SR_ESTABLISHED);
        while (!sock_established && waited < cycles_per_frame) begin
            @(negedge clk);
            waited++;
        end
        check_flag(sock_established, 1'b1, "sock_established after ESTABLISHED");
        repeat (hold_cycles) begin
            @(negedge clk);
            check_flag(sock_established, 1'b1, "sock_established held");
            check_flag(xfer.start, 1'b0, "no start once established");
        end
        check_flag(xfer_q.size() == 0, 1'b1, "no frame once established");
    endtask

    initial begin
        rst             = 1'b1;
        tx_full         = 1'b0;
        busy            = 1'b0;
        rx_byte         = '0;
        rx_empty        = 1'b1;
        stall_en        = 1'b0;
        read_xfer       = 1'b0;
        busy_left       = 0;
        cycle           = 0;
        last_push_cycle = 0;
        void'($urandom(32'h4c1d));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        for (int s = 0; s < 4; s++) begin
            check_init_frame(s);
        end
        test_backpressure_mac();
        for (int s = 5; s < `W5500_INIT_REGS; s++) begin
            check_init_frame(s);
        end
        test_first_poll();
        test_status_response(`W5500_SR_CLOSED, 1'b1, `W5500_CMD_OPEN, "CLOSED");
        test_status_response(`W5500_SR_INIT, 1'b1, `W5500_CMD_LISTEN, "INIT");
        test_status_response(`W5500_SR_CLOSE_WAIT, 1'b1, `W5500_CMD_DISCON, "CLOSE_WAIT");
        test_status_response(`W5500_SR_LISTEN, 1'b0, 8'h00, "LISTEN");
        test_established();
        if (i_dut.i_asserts.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_run("a protocol assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/w5500_pkg.sv
logic/w5500_init_rom.sv
logic/w5500_frame_writer.sv
logic/w5500_socket_sequencer.sv
logic/w5500_ctrl_top.sv
testbench/w5500_ctrl_asserts.sv
testbench/w5500_ctrl_tb.sv
